// File: flist.f
logic/nes_host_pkg.sv
logic/nes_timing_pkg.sv
logic/host_regs.sv
logic/joypad_serial.sv
logic/bus_scheduler.sv
logic/meminit_watchdog.sv
logic/nes_host_top.sv
sim/nes_host_assertions.sv
sim/tb_nes_host.sv

// File: sim/tb_nes_host.sv
/*
 * Testbench for nes_host_top. Drives host writes, controller, loader,
 * core and calibration traffic; the bound u_checks instance does the checking.
 */

`timescale 1ns/1ns

module tb_nes_host import nes_host_pkg::*, nes_timing_pkg::*;;

  logic       clk, reset;
  byte_t      host_addr, host_data;
  logic       host_write, joypad_strobe;
  logic [1:0] joypad_clock, joypad_data;
  logic       loader_done, loader_write, loader_refresh;
  mem_addr_t  loader_addr, nes_addr, mem_addr;
  byte_t      loader_wdata, nes_wdata, loader_data, nes_config, osd_data, mem_din;
  logic       nes_read_cpu, nes_read_ppu, nes_write;
  logic       write_level_done, read_calib_done, fail_high, fail_low;
  logic       loader_reset, loader_strobe, osd_enable, osd_we;
  osd_addr_t  osd_addr;
  logic       run_nes, nes_reset, mem_read_cpu, mem_read_ppu, mem_write, mem_refresh;
  logic       mem_reset, meminit_check, mem_ok;

  nes_host_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(negedge clk) begin
    if (dut.u_checks.fail_count != 0) begin
      $display("SIMULATION FAILED");
      $fatal(1, "assertion check failed, see the error above");
    end
  end

  task automatic write_reg(input byte_t addr, input byte_t data);
    @(negedge clk);
    host_addr  = addr;
    host_data  = data;
    host_write = 1'b1;
    @(negedge clk);
    host_write = 1'b0;
  endtask

  task automatic stop_on_timeout(input string what);
    $display("SIMULATION FAILED");
    $fatal(1, "timed out waiting for %s", what);
  endtask

  function automatic logic seen(input string what);
    case (what)
      "run_nes":   return run_nes;
      "mem_reset": return mem_reset;
      default:     return meminit_check;
    endcase
  endfunction

  // steps at least one falling edge, so a pulse already seen is skipped
  task automatic wait_for(input string what, input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > limit) stop_on_timeout(what);
    end while (!seen(what));
  endtask

  initial begin
    logic [31:0] r;
    void'($urandom(89897));
    {host_write, joypad_strobe, loader_done, loader_write, loader_refresh} = '0;
    {nes_read_cpu, nes_read_ppu, nes_write, fail_high, fail_low, read_calib_done} = '0;
    {host_addr, host_data, loader_addr, loader_wdata, nes_addr, nes_wdata} = '0;
    joypad_clock     = 2'b11;  // idle high, shifts on the fall
    write_level_done = 1'b1;
    reset            = 1'b1;
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // controller ports
    write_reg(reg_btn1, byte_t'($urandom));
    write_reg(reg_btn2, byte_t'($urandom));
    @(negedge clk);
    joypad_strobe = 1'b1;
    @(negedge clk);
    joypad_strobe = 1'b0;
    repeat (9) begin  // one past the last button
      @(negedge clk);
      joypad_clock = 2'b00;
      @(negedge clk);
      joypad_clock = 2'b11;
    end

    // display and loader registers
    write_reg(reg_osd_lo, byte_t'($urandom));
    write_reg(reg_osd_hi, byte_t'($urandom));
    repeat (4) write_reg(reg_osd_data, byte_t'($urandom));
    write_reg(reg_osd_en, 8'h01);
    write_reg(reg_osd_en, 8'h00);
    write_reg(reg_config, byte_t'($urandom));
    write_reg(reg_loader_conf, 8'h01);
    write_reg(reg_loader_data, byte_t'($urandom));
    write_reg(reg_loader_conf, 8'h00);

    // loading phase, core held
    repeat (30) begin
      @(negedge clk);
      r = $urandom;
      loader_write   = r[0];
      loader_refresh = r[1];
      nes_read_cpu   = r[2];
      loader_addr    = mem_addr_t'($urandom);
      loader_wdata   = byte_t'($urandom);
    end
    @(negedge clk);
    {loader_write, loader_refresh} = '0;
    loader_done = 1'b1;
    wait_for("run_nes", 12);

    // core traffic, about half the slots idle
    repeat (90) begin
      @(negedge clk);
      r = $urandom;
      nes_read_cpu = r[0] && r[1];
      nes_read_ppu = r[2] && r[3];
      nes_write    = r[4] && r[5] && r[6];
      nes_addr     = mem_addr_t'($urandom);
      nes_wdata    = byte_t'($urandom);
    end

    // calibration keeps failing, then passes
    wait_for("mem_reset", meminit_period + 10);
    wait_for("mem_reset", meminit_period + 10);
    read_calib_done = 1'b1;
    wait_for("meminit_check", meminit_period + 10);
    repeat (meminit_period + 20) @(negedge clk);

    if (dut.u_checks.fail_count == 0) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("SIMULATION FAILED");
      $fatal(1, "%0d assertion failures", dut.u_checks.fail_count);
    end
  end

endmodule

// File: sim/nes_host_assertions.sv
/*
 * Concurrent checks on the host glue, bound into every nes_host_top.
 * A failing check raises $error and bumps fail_count for the testbench.
 */

`timescale 1ns/1ns

module nes_host_assertions import nes_host_pkg::*, nes_timing_pkg::*; (
  input logic       clk, reset,
  input byte_t      host_addr, host_data, loader_data, osd_data, mem_din, loader_wdata,
  input byte_t      nes_config,
  input logic       host_write, joypad_strobe, osd_we, osd_enable, loader_strobe, loader_reset,
  input logic [1:0] joypad_clock, joypad_data,
  input osd_addr_t  osd_addr,
  input mem_addr_t  loader_addr, mem_addr,
  input logic       loader_done, loader_write, loader_refresh, run_nes, nes_reset,
  input logic       nes_read_cpu, nes_read_ppu, nes_write, mem_read_cpu, mem_write, mem_refresh,
  input logic       mem_read_ppu,
  input logic       write_level_done, read_calib_done, fail_high, fail_low,
  input logic       mem_reset, meminit_check, mem_ok
);

  int fail_count = 0;

  byte_t      btn_model [2];  // button bytes as the host wrote them
  byte_t      pad_model [2];
  logic [1:0] clk_prev;
  logic       cal_bad;

  assign cal_bad = !write_level_done || !read_calib_done || (fail_high && fail_low);

  task automatic report_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  // reference controller shifters
  always_ff @(posedge clk) begin
    if (reset) begin
      btn_model <= '{default: '0};
      pad_model <= '{default: '0};
      clk_prev  <= '0;
    end else begin
      if (host_write && host_addr == reg_btn1) btn_model[0] <= host_data;
      if (host_write && host_addr == reg_btn2) btn_model[1] <= host_data;
      for (int i = 0; i < 2; i++) begin
        if (clk_prev[i] && !joypad_clock[i])
          pad_model[i] <= pad_model[i] >> 1;  // shift beats load
        else if (joypad_strobe)
          pad_model[i] <= btn_model[i];
      end
      clk_prev <= joypad_clock;
    end
  end

  a_pad: assert property (@(posedge clk) disable iff (reset)
      joypad_data == {pad_model[1][0], pad_model[0][0]})
    else report_failure($sformatf("ERROR joypad_data %h, expected %h", $sampled(joypad_data),
      {$sampled(pad_model[1][0]), $sampled(pad_model[0][0])}));

  // display writes
  a_osd_we: assert property (@(posedge clk) disable iff (reset)
      host_write && host_addr == reg_osd_data |-> osd_we && osd_data == host_data)
    else report_failure($sformatf("ERROR osd_data %h, expected %h", $sampled(osd_data),
      $sampled(host_data)));
  a_osd_inc: assert property (@(posedge clk) disable iff (reset)
      osd_we |=> osd_addr == $past(osd_addr) + 12'd1)
    else report_failure($sformatf("ERROR osd_addr %h did not step by one", $sampled(osd_addr)));
  a_osd_lo: assert property (@(posedge clk) disable iff (reset)
      host_write && host_addr == reg_osd_lo |=> osd_addr[7:0] == $past(host_data))
    else report_failure($sformatf("ERROR osd_addr %h, low byte not written", $sampled(osd_addr)));
  a_osd_hi: assert property (@(posedge clk) disable iff (reset)
      host_write && host_addr == reg_osd_hi |=> osd_addr[11:8] == $past(host_data[3:0]))
    else report_failure($sformatf("ERROR osd_addr %h, high nibble not written",
      $sampled(osd_addr)));
  a_osd_en: assert property (@(posedge clk) disable iff (reset)
      host_write && host_addr == reg_osd_en |=> osd_enable == $past(host_data[0]))
    else report_failure($sformatf("ERROR osd_enable %h", $sampled(osd_enable)));

  // loader control
  a_ld_data: assert property (@(posedge clk) disable iff (reset)
      host_write && host_addr == reg_loader_data |-> loader_strobe && loader_data == host_data)
    else report_failure($sformatf("ERROR loader_data %h, expected %h", $sampled(loader_data),
      $sampled(host_data)));
  a_ld_conf: assert property (@(posedge clk) disable iff (reset)
      host_write && host_addr == reg_loader_conf |=> loader_reset == $past(host_data[0]))
    else report_failure($sformatf("ERROR loader_reset %h", $sampled(loader_reset)));
  a_config: assert property (@(posedge clk) disable iff (reset)
      host_write && host_addr == reg_config |=> nes_config == $past(host_data))
    else report_failure($sformatf("ERROR nes_config %h after config write",
      $sampled(nes_config)));

  // sequencer slots and request merge
  a_hold: assert property (@(posedge clk) disable iff (reset)
      !loader_done |-> nes_reset && !run_nes && mem_refresh == loader_refresh)
    else report_failure("core not held or refresh not from loader while loading");
  a_gap: assert property (@(posedge clk) disable iff (reset) run_nes |=> !run_nes [*5])
    else report_failure("run_nes pulsed twice within six cycles");
  a_period: assert property (@(posedge clk) disable iff (reset)
      run_nes ##1 loader_done [*6] |-> run_nes)
    else report_failure("run_nes did not recur after six cycles");
  a_cpu_slot: assert property (@(posedge clk) disable iff (reset)
      nes_read_cpu && loader_done ##1 loader_done [*5] |-> run_nes == $past(mem_read_cpu, 5))
    else report_failure("core read not forwarded exactly five cycles before run_nes");
  a_ppu_slot: assert property (@(posedge clk) disable iff (reset)
      nes_read_ppu && loader_done ##1 loader_done [*5] |-> run_nes == $past(mem_read_ppu, 5))
    else report_failure("core PPU read not forwarded exactly five cycles before run_nes");
  a_refresh: assert property (@(posedge clk) disable iff (reset)
      loader_done && !(nes_read_cpu || nes_read_ppu || nes_write) ##1 loader_done [*5]
      |-> run_nes == $past(mem_refresh, 5))
    else report_failure("refresh not in the idle memory slot");
  a_ld_write: assert property (@(posedge clk) disable iff (reset)
      loader_write |-> mem_write && mem_addr == loader_addr && mem_din == loader_wdata)
    else report_failure($sformatf("ERROR mem_addr %h mem_din %h, expected %h %h",
      $sampled(mem_addr), $sampled(mem_din), $sampled(loader_addr), $sampled(loader_wdata)));

  // calibration retry
  a_retry_gap: assert property (@(posedge clk) disable iff (reset)
      mem_reset |=> !mem_reset [*meminit_period - 1])
    else report_failure("mem_reset came back before a full interval");
  a_retry: assert property (@(posedge clk) disable iff (reset)
      mem_reset ##1 cal_bad [*meminit_period - 1] |=> mem_reset)
    else report_failure("failing calibration did not retry mem_reset");
  a_check: assert property (@(posedge clk) disable iff (reset)
      meminit_check |-> mem_ok == !$past(cal_bad))
    else report_failure($sformatf("ERROR mem_ok %h after check", $sampled(mem_ok)));
  a_ok_hold: assert property (@(posedge clk) disable iff (reset)
      mem_ok |-> !mem_reset ##1 mem_ok)
    else report_failure("mem_reset or mem_ok drop after a good check");

endmodule

bind nes_host_top nes_host_assertions u_checks (.*);

// File: logic/nes_host_top.sv
/*
 * Host-side glue around the emulator core, loader and DRAM controller.
 * Those blocks sit outside and connect through the ports here.
 */

`timescale 1ns/1ns

module nes_host_top import nes_host_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  // decoded serial link
  input  byte_t      host_addr,
  input  byte_t      host_data,
  input  logic       host_write,
  // controller port, driven by the core
  input  logic       joypad_strobe,
  input  logic [1:0] joypad_clock,
  // loader
  input  logic       loader_done,
  input  logic       loader_write,
  input  logic       loader_refresh,
  input  mem_addr_t  loader_addr,
  input  byte_t      loader_wdata,
  // core memory requests
  input  logic       nes_read_cpu,
  input  logic       nes_read_ppu,
  input  logic       nes_write,
  input  mem_addr_t  nes_addr,
  input  byte_t      nes_wdata,
  // DRAM controller status
  input  logic       write_level_done,
  input  logic       read_calib_done,
  input  logic       fail_high,
  input  logic       fail_low,
  output logic       loader_reset,
  output byte_t      loader_data,
  output logic       loader_strobe,
  output byte_t      nes_config,
  output osd_addr_t  osd_addr,
  output logic       osd_enable,
  output byte_t      osd_data,
  output logic       osd_we,
  output logic [1:0] joypad_data,
  output logic       run_nes,
  output logic       nes_reset,
  output logic       mem_read_cpu,
  output logic       mem_read_ppu,
  output logic       mem_write,
  output logic       mem_refresh,
  output mem_addr_t  mem_addr,
  output byte_t      mem_din,
  output logic       mem_reset,
  output logic       meminit_check,
  output logic       mem_ok
);

  byte_t btn1;  // button bytes from the host, to the shifters
  byte_t btn2;

  host_regs u_regs (
    .clk, .reset, .host_addr, .host_data, .host_write,
    .loader_reset, .loader_data, .loader_strobe, .nes_config,
    .btn1, .btn2, .osd_addr, .osd_enable, .osd_data, .osd_we
  );

  joypad_serial u_joypad (
    .clk, .reset, .btn1, .btn2, .joypad_strobe, .joypad_clock, .joypad_data
  );

  bus_scheduler u_sched (
    .clk, .reset, .loader_done, .loader_write, .loader_refresh,
    .loader_addr, .loader_wdata, .nes_read_cpu, .nes_read_ppu,
    .nes_write, .nes_addr, .nes_wdata, .run_nes, .nes_reset,
    .mem_read_cpu, .mem_read_ppu, .mem_write, .mem_refresh,
    .mem_addr, .mem_din
  );

  meminit_watchdog u_watchdog (
    .clk, .reset, .write_level_done, .read_calib_done, .fail_high, .fail_low,
    .mem_reset, .meminit_check, .mem_ok
  );

endmodule

// File: logic/meminit_watchdog.sv
/*
 * DRAM calibration watchdog.
 * Looks at the controller status once per interval and pulses the
 * controller reset until write leveling and read calibration both pass.
 */

`timescale 1ns/1ns

module meminit_watchdog import nes_timing_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic write_level_done,
  input  logic read_calib_done,
  input  logic fail_high,
  input  logic fail_low,
  output logic mem_reset,
  output logic meminit_check,
  output logic mem_ok
);

  localparam meminit_cnt_t reload = meminit_cnt_t'(meminit_period);

  meminit_cnt_t cnt;
  logic         status_bad;

  // both byte lanes failing the test counts as bad too
  assign status_bad = !write_level_done || !read_calib_done || (fail_high && fail_low);

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt           <= reload;
      mem_reset     <= 1'b0;
      meminit_check <= 1'b0;
      mem_ok        <= 1'b0;
    end else begin
      mem_reset     <= 1'b0;  // single-cycle pulses
      meminit_check <= 1'b0;

      if (cnt != '0)
        cnt <= cnt - 1'b1;  // parks at zero after a good check

      if (cnt == meminit_cnt_t'(1)) begin
        meminit_check <= 1'b1;
        mem_ok        <= !status_bad;
        if (status_bad) begin
          mem_reset <= 1'b1;
          cnt       <= reload;  // try again next interval
        end
      end
    end
  end

endmodule

// File: logic/bus_scheduler.sv
/*
 * Six-phase sequencer and memory request merge.
 * Memory gets phase 0, the core runs in phase 5 once the loader is done;
 * loader writes take the port over while they are active.
 */

`timescale 1ns/1ns

module bus_scheduler import nes_host_pkg::*, nes_timing_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      loader_done,
  input  logic      loader_write,
  input  logic      loader_refresh,
  input  mem_addr_t loader_addr,
  input  byte_t     loader_wdata,
  input  logic      nes_read_cpu,
  input  logic      nes_read_ppu,
  input  logic      nes_write,
  input  mem_addr_t nes_addr,
  input  byte_t     nes_wdata,
  output logic      run_nes,
  output logic      nes_reset,
  output logic      mem_read_cpu,
  output logic      mem_read_ppu,
  output logic      mem_write,
  output logic      mem_refresh,
  output mem_addr_t mem_addr,
  output byte_t     mem_din
);

  // phase   0       1       2       3       4       5
  // memory  cmd                             data
  // core                                            step
  phase_t phase;
  logic   run_mem;
  logic   nes_req;

  always_ff @(posedge clk) begin
    if (reset)
      phase <= phase_mem;
    else if (phase == phase_last)
      phase <= '0;
    else
      phase <= phase + 3'd1;
  end

  assign nes_reset = !loader_done;  // core held until the ROM is in
  assign run_mem   = (phase == phase_mem) && loader_done;
  assign run_nes   = (phase == phase_nes) && loader_done;

  assign nes_req = nes_read_cpu || nes_read_ppu || nes_write;

  assign mem_read_cpu = nes_read_cpu && run_mem;
  assign mem_read_ppu = nes_read_ppu && run_mem;
  assign mem_write    = (nes_write && run_mem) || loader_write;

  // idle memory slot becomes a refresh; loader picks its own before that
  assign mem_refresh = loader_done ? (run_mem && !nes_req) : loader_refresh;

  assign mem_addr = loader_write ? loader_addr : nes_addr;
  assign mem_din  = loader_write ? loader_wdata : nes_wdata;

endmodule

// File: logic/joypad_serial.sv
/*
 * Two serial controller ports as seen by the emulator core.
 * The strobe loads the button bytes, a falling clock edge shifts one bit out.
 */

`timescale 1ns/1ns

module joypad_serial import nes_host_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  byte_t      btn1,
  input  byte_t      btn2,
  input  logic       joypad_strobe,
  input  logic [1:0] joypad_clock,
  output logic [1:0] joypad_data
);

  byte_t      shift_q [2];
  logic [1:0] last_clock;  // previous joypad_clock for edge detect
  byte_t      btn [2];

  assign btn[0] = btn1;
  assign btn[1] = btn2;

  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q[0] <= '0;
      shift_q[1] <= '0;
      last_clock <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        // falling edge shifts, and wins over a load in the same cycle
        if (!joypad_clock[i] && last_clock[i])
          shift_q[i] <= {1'b0, shift_q[i][7:1]};
        else if (joypad_strobe)
          shift_q[i] <= btn[i];
      end
      last_clock <= joypad_clock;
    end
  end

  assign joypad_data = {shift_q[1][0], shift_q[0][0]};  // LSB first

endmodule

// File: logic/host_regs.sv
/*
 * Host control registers written over the serial link.
 * Each host_write strobe carries one address byte and one data byte.
 */

`timescale 1ns/1ns

module host_regs import nes_host_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  byte_t     host_addr,
  input  byte_t     host_data,
  input  logic      host_write,
  output logic      loader_reset,
  output byte_t     loader_data,
  output logic      loader_strobe,
  output byte_t     nes_config,
  output byte_t     btn1,
  output byte_t     btn2,
  output osd_addr_t osd_addr,
  output logic      osd_enable,
  output byte_t     osd_data,
  output logic      osd_we
);

  logic wr_loader_conf;
  logic wr_config;
  logic wr_btn1;
  logic wr_btn2;
  logic wr_osd_lo;
  logic wr_osd_hi;
  logic wr_osd_en;

  assign wr_loader_conf = host_write && (host_addr == reg_loader_conf);
  assign wr_config      = host_write && (host_addr == reg_config);
  assign wr_btn1        = host_write && (host_addr == reg_btn1);
  assign wr_btn2        = host_write && (host_addr == reg_btn2);
  assign wr_osd_lo      = host_write && (host_addr == reg_osd_lo);
  assign wr_osd_hi      = host_write && (host_addr == reg_osd_hi);
  assign wr_osd_en      = host_write && (host_addr == reg_osd_en);

  // data bytes pass straight through, strobe in the write cycle
  assign loader_data   = host_data;
  assign loader_strobe = host_write && (host_addr == reg_loader_data);
  assign osd_data      = host_data;
  assign osd_we        = host_write && (host_addr == reg_osd_data);

  always_ff @(posedge clk) begin
    if (reset) begin
      loader_reset <= 1'b0;
      nes_config   <= '0;
      btn1         <= '0;
      btn2         <= '0;
      osd_addr     <= '0;
      osd_enable   <= 1'b0;
    end else begin
      if (wr_loader_conf) loader_reset <= host_data[0];
      if (wr_config)      nes_config <= host_data;
      if (wr_btn1)        btn1 <= host_data;
      if (wr_btn2)        btn2 <= host_data;
      if (wr_osd_en)      osd_enable <= host_data[0];

      // display address, only one of these can hit per write
      if (wr_osd_lo)
        osd_addr[7:0] <= host_data;
      else if (wr_osd_hi)
        osd_addr[11:8] <= host_data[3:0];  // upper nibble of 12 bits
      else if (osd_we)
        osd_addr <= osd_addr + 12'd1;      // step after each data byte
    end
  end

endmodule

// File: logic/nes_timing_pkg.sv
/*
 * Cycle sequencer phases and memory-init watchdog interval.
 * Used by the bus scheduler, the watchdog and the testbench.
 */

package nes_timing_pkg;

  typedef logic [2:0] phase_t;

  // six clocks per core cycle, phase 0 through 5
  localparam phase_t phase_last = 3'd5;
  localparam phase_t phase_mem  = 3'd0;  // memory command slot
  localparam phase_t phase_nes  = 3'd5;  // core advances here, read data ready

  // calibration check interval in clocks
  // short for simulation; the board waits about 0.2 s
  localparam int meminit_period = 250;

  typedef logic [$clog2(meminit_period + 1) - 1:0] meminit_cnt_t;

endpackage

// File: logic/nes_host_pkg.sv
/*
 * Host-side register map and bus widths for the console top level.
 * Imported by the register decoder, the top level and the testbench.
 */

package nes_host_pkg;

  typedef logic [7:0]  byte_t;      // one host data byte
  typedef logic [21:0] mem_addr_t;  // 4 MB memory space
  typedef logic [11:0] osd_addr_t;  // display buffer index

  // loader registers
  localparam byte_t reg_loader_conf = 8'h35;  // bit 0 holds the loader in reset
  localparam byte_t reg_config      = 8'h36;
  localparam byte_t reg_loader_data = 8'h37;  // one ROM byte per write

  // controller button bytes
  localparam byte_t reg_btn1 = 8'h40;
  localparam byte_t reg_btn2 = 8'h41;

  // on-screen display
  localparam byte_t reg_osd_lo   = 8'h80;
  localparam byte_t reg_osd_hi   = 8'h81;  // low nibble only
  localparam byte_t reg_osd_data = 8'h82;  // address auto-increments
  localparam byte_t reg_osd_en   = 8'h83;

endpackage
